// ==== Makefile ====
TOP := rv32_ctrl_pipe_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// ==== rv32_branch_stage.sv ====
// Second pipe stage: resolves the branch next-PC select and registers the final control word
`timescale 1ns/100ps

module rv32_branch_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  rv32_ctrl_pkg::dec_mid_t   mid,
    input  logic                      mid_valid,
    output logic                      mid_ready,
    output rv32_ctrl_pkg::ctrl_word_t ctrl,
    output logic                      ctrl_valid,
    input  logic                      ctrl_ready
);

    import rv32_ctrl_pkg::*;

    logic       taken;
    ctrl_word_t ctrl_next;

    // Condition from funct3 and the carried compare flags
    always_comb begin
        case (mid.funct3)
            f3_beq:  taken = mid.br_eq;
            f3_bne:  taken = !mid.br_eq;
            f3_blt:  taken = mid.br_lt;
            f3_bge:  taken = !mid.br_lt;
            f3_bltu: taken = mid.br_ltu;
            f3_bgeu: taken = !mid.br_ltu;
            default: taken = 1'b0;       // 010, 011 never branch
        endcase
    end

    always_comb begin
        ctrl_next = mid.ctrl;                        // Non-branch passes as is
        if (mid.is_branch) begin
            ctrl_next.pc_sel = taken ? pc_branch : pc_plus4;
        end
    end

    assign mid_ready = !ctrl_valid || ctrl_ready;   // Empty or draining

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_valid <= 1'b0;
        end else if (mid_ready) begin
            ctrl_valid <= mid_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mid_valid && mid_ready) begin
            ctrl <= ctrl_next;
        end
    end

endmodule

// ==== rv32_ctrl_pipe.sv ====
// Top of the two-stage RV32I control pipe, tokens in on req and control words out on ctrl
`timescale 1ns/100ps

module rv32_ctrl_pipe (
    input  logic                      clk,
    input  logic                      rst_n,
    input  rv32_ctrl_pkg::dec_req_t   req,        // Instruction plus compare flags
    input  logic                      req_valid,
    output logic                      req_ready,
    output rv32_ctrl_pkg::ctrl_word_t ctrl,       // Fully resolved control word
    output logic                      ctrl_valid,
    input  logic                      ctrl_ready
);

    import rv32_ctrl_pkg::*;

    dec_mid_t mid;        // Decoded, branch still open
    logic     mid_valid;
    logic     mid_ready;

    // Table lookup
    rv32_decode_stage rv32_decode_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .mid       (mid),
        .mid_valid (mid_valid),
        .mid_ready (mid_ready)
    );

    // Branch resolve
    rv32_branch_stage rv32_branch_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .mid        (mid),
        .mid_valid  (mid_valid),
        .mid_ready  (mid_ready),
        .ctrl       (ctrl),
        .ctrl_valid (ctrl_valid),
        .ctrl_ready (ctrl_ready)
    );

endmodule

// ==== rv32_ctrl_pipe_checker.sv ====
// Handshake and reset assertions, bound into every rv32_ctrl_pipe instance for simulation
`timescale 1ns/100ps

module rv32_ctrl_pipe_checker (
    input logic                      clk,
    input logic                      rst_n,
    input rv32_ctrl_pkg::dec_req_t   req,
    input logic                      req_valid,
    input logic                      req_ready,
    input rv32_ctrl_pkg::dec_mid_t   mid,
    input logic                      mid_valid,
    input logic                      mid_ready,
    input rv32_ctrl_pkg::ctrl_word_t ctrl,
    input logic                      ctrl_valid,
    input logic                      ctrl_ready
);

    // Stalled tokens stay put on every link
    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else $error("req token changed while stalled");

    mid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mid_valid && !mid_ready |=> mid_valid && $stable(mid))
        else $error("mid token changed while stalled");

    ctrl_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_valid && !ctrl_ready |=> ctrl_valid && $stable(ctrl))
        else $error("ctrl word changed while stalled");

    // Both stages empty in reset
    reset_empty: assert property (@(posedge clk)
        !rst_n |-> !ctrl_valid && !mid_valid)
        else $error("valid high during reset");

    ebreak_clean: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_valid && ctrl.is_ebreak |-> !ctrl.rf_we && !ctrl.mem_en)
        else $error("EBREAK word writes registers or memory");

endmodule

bind rv32_ctrl_pipe rv32_ctrl_pipe_checker rv32_ctrl_pipe_checker_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .mid        (mid),
    .mid_valid  (mid_valid),
    .mid_ready  (mid_ready),
    .ctrl       (ctrl),
    .ctrl_valid (ctrl_valid),
    .ctrl_ready (ctrl_ready)
);

// ==== rv32_ctrl_pipe_tb.sv ====
// Directed testbench for the RV32I control pipe that verilog.f compiles and the Makefile runs
`timescale 1ns/100ps

module rv32_ctrl_pipe_tb;

    import rv32_ctrl_pkg::*;

    localparam int clk_period      = 8;
    localparam int reset_cycles    = 8;
    localparam int token_budget    = 300;                       // Above the ~210 tokens sent
    localparam int watchdog_cycles = reset_cycles + token_budget * 6 + 200;

    logic         clk;
    logic         rst_n;
    dec_req_t     req;
    logic         req_valid;
    logic         req_ready;
    ctrl_word_t   ctrl;
    logic         ctrl_valid;
    logic         ctrl_ready = 1'b1;
    integer       seed;
    int           errors;                                       // Main thread failures
    int           checks;
    int           mon_errors;                                   // Output monitor failures
    int           compared;
    int           tests;
    int           base_errors;
    int           base_checks;
    int           edge_cnt;                                     // Edges since reset release
    logic         check_latency;
    logic [255:0] ready_pattern;                                // Per-cycle ctrl_ready
    logic [7:0]   pat_idx;
    logic         ready_draw = 1'b1;
    dec_req_t     sent_q[$];                                    // Accepted and not yet out
    int           accept_q[$];
    dec_req_t     out_req;
    int           out_acc;
    ctrl_word_t   exp_word;

    rv32_ctrl_pipe rv32_ctrl_pipe_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .ctrl       (ctrl),
        .ctrl_valid (ctrl_valid),
        .ctrl_ready (ctrl_ready)
    );

    always #(clk_period / 2) clk = ~clk;

    // Reference decoder built from the control table
    function automatic ctrl_word_t expected_ctrl(dec_req_t r);
        ctrl_word_t w;
        logic [6:0] op;
        logic [6:0] f7;
        logic [2:0] f3;
        logic       ok;
        logic       taken;
        alu_op_e    a;
        w  = '0;
        op = r.inst.r_view.opcode;
        f7 = r.inst.r_view.funct7;
        f3 = r.inst.r_view.funct3;
        ok = (op == opc_op_imm) || (f7 == 7'h00);               // OP needs funct7 zero
        a  = alu_add;
        case (f3)
            3'd0: begin
                if (op == opc_op && f7 == 7'h20) begin
                    a  = alu_sub;
                    ok = 1'b1;
                end
            end
            3'd1: a = alu_sll;
            3'd2: a = alu_slt;
            3'd3: a = alu_sltu;
            3'd4: a = alu_xor;
            3'd5: begin
                a  = (f7 == 7'h20) ? alu_sra : alu_srl;
                ok = (f7 == 7'h00) || (f7 == 7'h20);            // SRLI/SRAI too
            end
            3'd6: a = alu_or;
            default: a = alu_and;
        endcase
        case (f3)
            3'd0: taken = r.br_eq;
            3'd1: taken = !r.br_eq;
            3'd4: taken = r.br_lt;
            3'd5: taken = !r.br_lt;
            3'd6: taken = r.br_ltu;
            3'd7: taken = !r.br_ltu;
            default: taken = 1'b0;
        endcase
        case (op)
            opc_op, opc_op_imm: begin
                if (ok) begin
                    w.alu_op  = a;
                    w.op2_sel = (op == opc_op) ? op2_rs2 : op2_imm;
                    w.rf_we   = 1'b1;
                    w.wb_sel  = wb_alu;
                end
            end
            opc_load: begin
                if (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) begin
                    w.op2_sel    = op2_imm;
                    w.rf_we      = 1'b1;
                    w.mem_en     = 1'b1;
                    w.wb_sel     = wb_mem;
                    w.mem_access = f3;
                end
            end
            opc_store: begin
                if (f3 inside {3'd0, 3'd1, 3'd2}) begin
                    w.op2_sel    = op2_simm;
                    w.mem_en     = 1'b1;
                    w.mem_wen    = 1'b1;
                    w.mem_access = f3;
                end
            end
            opc_branch: begin
                if (!(f3 inside {3'd2, 3'd3})) begin
                    w.pc_sel = taken ? pc_branch : pc_plus4;
                    w.wb_sel = wb_alu;
                end
            end
            opc_jal: begin
                w.pc_sel = pc_jal;
                w.rf_we  = 1'b1;
                w.wb_sel = wb_pc_plus4;
            end
            opc_jalr: begin
                if (f3 == 3'd0) begin
                    w.op2_sel = op2_imm;
                    w.pc_sel  = pc_jalr;
                    w.rf_we   = 1'b1;
                    w.wb_sel  = wb_pc_plus4;
                end
            end
            opc_auipc: begin
                w.op1_sel = op1_pc;
                w.rf_we   = 1'b1;
                w.wb_sel  = wb_alu;
            end
            opc_lui: begin
                w.alu_op  = alu_lui;
                w.op1_sel = op1_pc;
                w.rf_we   = 1'b1;
                w.wb_sel  = wb_alu;
            end
            opc_system: w.is_ebreak = (r.inst == 32'h0010_0073);   // Canonical EBREAK only
            default: w = '0;
        endcase
        return w;
    endfunction

    function automatic logic [31:0] random_word();
        random_word = $random(seed);
    endfunction

    function automatic logic [2:0] random_flags();
        logic [31:0] rnd;
        rnd = random_word();
        return rnd[2:0];
    endfunction

    // Given fields plus random rs2, rs1, rd
    function automatic logic [31:0] build_inst(logic [6:0] f7, logic [2:0] f3, logic [6:0] op);
        logic [31:0] rnd;
        rnd = random_word();
        return {f7, rnd[14:10], rnd[9:5], f3, rnd[4:0], op};
    endfunction

    function automatic dec_req_t make_token(logic [31:0] w, logic [2:0] flags);
        dec_req_t t;
        t.inst   = w;
        t.br_eq  = flags[2];
        t.br_lt  = flags[1];
        t.br_ltu = flags[0];
        return t;
    endfunction

    function automatic dec_req_t random_token();
        logic [6:0]  ops [16];
        logic [31:0] rnd;
        logic [31:0] w;
        ops = '{opc_lui, opc_auipc, opc_jal, opc_jalr, opc_branch, opc_branch, opc_load,
                opc_load, opc_store, opc_op_imm, opc_op_imm, opc_op, opc_op, opc_system,
                7'b0001111, 7'b1111111};                        // Last two unknown
        rnd    = random_word();
        w      = random_word();
        w[6:0] = ops[rnd[3:0]];
        if (rnd[4]) begin
            w[31:25] = 7'h00;                                   // Favor legal funct7
        end
        if (rnd[5] && w[6:0] == opc_system) begin
            w = 32'h0010_0073;
        end
        return make_token(w, rnd[10:8]);
    endfunction

    // Hold the token until the pipe takes it
    task automatic send_token(input dec_req_t t);
        logic taken;
        req       = t;
        req_valid = 1'b1;
        taken     = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = req_ready;                                  // Stable until next edge
            @(posedge clk);
            #1;                                                 // Back 1 ns after the edge
        end
        req_valid = 1'b0;
    endtask

    task automatic send_inst(input logic [31:0] w);
        send_token(make_token(w, random_flags()));
    endtask

    task automatic drain_pipe();
        int waited;
        waited = 0;
        while ((sent_q.size() != 0 || ctrl_valid) && waited < 64) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (sent_q.size() != 0) begin
            $display("Pipe failed to drain at %0t, %0d tokens never came out",
                     $time, sent_q.size());
            errors++;
        end
    endtask

    task automatic begin_test();
        base_errors = errors + mon_errors;
        base_checks = checks + compared;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("%s: %0d checks, %0d errors", name, checks + compared - base_checks,
                 errors + mon_errors - base_errors);
    endtask

    task automatic check_after_reset();
        begin_test();
        @(posedge clk);
        #1;
        checks += 2;
        if (ctrl_valid !== 1'b0) begin
            $display("Mismatch at %0t: ctrl_valid %b after reset", $time, ctrl_valid);
            errors++;
        end
        if (req_ready !== 1'b1) begin
            $display("Mismatch at %0t: req_ready %b after reset", $time, req_ready);
            errors++;
        end
        end_test("reset");
    endtask

    task automatic decode_alu_ops();
        logic [31:0] rnd;
        begin_test();
        rnd = random_word();                                    // Immediate upper bits
        send_inst(build_inst(7'h00, 3'd0, opc_op));             // ADD
        send_inst(build_inst(7'h20, 3'd0, opc_op));             // SUB
        send_inst(build_inst(7'h00, 3'd1, opc_op));             // SLL
        send_inst(build_inst(7'h00, 3'd2, opc_op));
        send_inst(build_inst(7'h00, 3'd3, opc_op));
        send_inst(build_inst(7'h00, 3'd4, opc_op));             // XOR
        send_inst(build_inst(7'h00, 3'd5, opc_op));             // SRL
        send_inst(build_inst(7'h20, 3'd5, opc_op));             // SRA
        send_inst(build_inst(7'h00, 3'd6, opc_op));
        send_inst(build_inst(7'h00, 3'd7, opc_op));             // AND
        send_inst(build_inst(rnd[6:0], 3'd0, opc_op_imm));      // ADDI
        send_inst(build_inst(rnd[13:7], 3'd2, opc_op_imm));     // SLTI
        send_inst(build_inst(rnd[20:14], 3'd3, opc_op_imm));
        send_inst(build_inst(rnd[27:21], 3'd4, opc_op_imm));    // XORI
        send_inst(build_inst(rnd[31:25], 3'd6, opc_op_imm));
        send_inst(build_inst(rnd[24:18], 3'd7, opc_op_imm));    // ANDI
        send_inst(build_inst(7'h00, 3'd1, opc_op_imm));         // SLLI
        send_inst(build_inst(7'h00, 3'd5, opc_op_imm));
        send_inst(build_inst(7'h20, 3'd5, opc_op_imm));         // SRAI
        send_inst(build_inst(7'h21, 3'd0, opc_op));             // Bad funct7 on SUB
        send_inst(build_inst(7'h60, 3'd5, opc_op));             // Bad funct7 on SRA
        send_inst(build_inst(7'h01, 3'd0, opc_op));
        drain_pipe();
        end_test("alu ops");
    endtask

    // All eight funct3 for loads and stores with illegal ones decoding to zero
    task automatic decode_mem_ops();
        int f;
        logic [31:0] rnd;
        begin_test();
        for (f = 0; f < 8; f++) begin
            rnd = random_word();
            send_inst(build_inst(rnd[6:0], f[2:0], opc_load));
            send_inst(build_inst(rnd[13:7], f[2:0], opc_store));
        end
        drain_pipe();
        end_test("loads and stores");
    endtask

    task automatic resolve_branches();
        int f3;
        int fl;
        logic [31:0] rnd;
        begin_test();
        for (f3 = 0; f3 < 8; f3++) begin
            for (fl = 0; fl < 8; fl++) begin
                rnd = random_word();
                send_token(make_token(build_inst(rnd[6:0], f3[2:0], opc_branch), fl[2:0]));
            end
        end
        drain_pipe();
        end_test("branches");
    endtask

    task automatic decode_jumps_misc();
        logic [31:0] rnd;
        begin_test();
        rnd = random_word();
        send_inst({rnd[31:7], opc_jal});
        send_inst(build_inst(rnd[6:0], 3'd0, opc_jalr));
        send_inst(build_inst(rnd[13:7], 3'd1, opc_jalr));        // JALR funct3 must be 0
        send_inst({rnd[24:0], opc_lui});
        send_inst({rnd[31:7], opc_auipc});
        send_inst(32'h0010_0073);                               // EBREAK
        send_inst(32'h0000_0073);                               // ECALL
        send_inst(32'h0010_00f3);                               // EBREAK with rd 1
        send_inst(32'h0010_8073);                               // EBREAK with rs1 1
        send_inst({rnd[31:7], 7'b1111111});
        send_inst({rnd[31:7], 7'b0001111});                     // FENCE not in table
        drain_pipe();
        end_test("jumps and misc");
    endtask

    task automatic stream_with_stalls();
        int i;
        int start_edge;
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;
        begin_test();
        for (i = 0; i < 8; i++) begin
            rnd_a = random_word();
            rnd_b = random_word();
            ready_pattern[i * 32 +: 32] = rnd_a | rnd_b;        // Ready about 3 of 4 cycles
        end
        for (i = 0; i < 64; i++) begin
            send_token(random_token());
        end
        drain_pipe();
        ready_pattern = '1;
        repeat (3) begin
            @(posedge clk);
            #1;
        end
        check_latency = 1'b1;
        start_edge    = edge_cnt;
        for (i = 0; i < 32; i++) begin
            send_token(random_token());
        end
        checks++;
        if (edge_cnt - start_edge != 32) begin
            $display("Mismatch at %0t: 32 tokens at full rate took %0d cycles, expected 32",
                     $time, edge_cnt - start_edge);
            errors++;
        end
        drain_pipe();
        check_latency = 1'b0;
        end_test("stream");
    endtask

    always @(negedge clk) begin
        ready_draw <= ready_pattern[pat_idx];
        pat_idx    <= pat_idx + 8'd1;
    end

    always @(posedge clk) begin
        #1;
        ctrl_ready = ready_draw;
    end

    // Output side first so a token is never matched against itself
    always @(negedge clk) begin
        if (rst_n) begin
            if (ctrl_valid && ctrl_ready) begin
                if (sent_q.size() == 0) begin
                    $display("Control word %h came out with no token outstanding at %0t",
                             ctrl, $time);
                    mon_errors++;
                end else begin
                    out_req  = sent_q.pop_front();
                    out_acc  = accept_q.pop_front();
                    exp_word = expected_ctrl(out_req);
                    compared++;
                    if (ctrl !== exp_word) begin
                        $display("Mismatch at %0t: token %h expected %h got %h",
                                 $time, out_req, exp_word, ctrl);
                        mon_errors++;
                    end
                    if (check_latency && (edge_cnt - out_acc) != 2) begin
                        $display("Mismatch at %0t: token %h out after %0d edges, expected 2",
                                 $time, out_req, edge_cnt - out_acc);
                        mon_errors++;
                    end
                end
            end
            if (req_valid && req_ready) begin
                sent_q.push_back(req);
                accept_q.push_back(edge_cnt);
            end
            edge_cnt++;
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired after %0d cycles, the pipe stopped moving", watchdog_cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        seed          = 32'h9ffe497f;
        clk           = 1'b0;
        rst_n         = 1'b0;
        req           = '0;
        req_valid     = 1'b0;
        errors        = 0;
        checks        = 0;
        mon_errors    = 0;
        compared      = 0;
        tests         = 0;
        edge_cnt      = 0;
        check_latency = 1'b0;
        ready_pattern = '1;
        pat_idx       = 8'd0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_after_reset();
        decode_alu_ops();
        decode_mem_ops();
        resolve_branches();
        decode_jumps_misc();
        stream_with_stalls();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks + compared,
                 errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== rv32_ctrl_pkg.sv ====
// Shared encodings and token types for the RV32I control pipe, imported by every stage
package rv32_ctrl_pkg;

    // RV32I major opcodes
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_system = 7'b1110011;

    localparam logic [6:0] f7_base = 7'b0000000; // ADD, SRL and friends
    localparam logic [6:0] f7_alt  = 7'b0100000; // SUB, SRA, SRAI

    // Branch conditions in funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef enum logic [4:0] {
        alu_add  = 5'd0,
        alu_sub  = 5'd1,
        alu_slt  = 5'd2,
        alu_sltu = 5'd3,
        alu_xor  = 5'd4,
        alu_or   = 5'd5,
        alu_and  = 5'd6,
        alu_sll  = 5'd7,
        alu_srl  = 5'd8,
        alu_sra  = 5'd9,
        alu_lui  = 5'd10  // Pass immediate through
    } alu_op_e;

    typedef enum logic [1:0] {
        op1_rs1 = 2'd0,
        op1_pc  = 2'd1
    } op1_sel_e;

    typedef enum logic [1:0] {
        op2_none = 2'd0,
        op2_imm  = 2'd1,  // I-type immediate
        op2_simm = 2'd2,  // S-type immediate
        op2_rs2  = 2'd3
    } op2_sel_e;

    typedef enum logic [2:0] {
        pc_plus4  = 3'd0,
        pc_jalr   = 3'd1,
        pc_branch = 3'd2,
        pc_jal    = 3'd3
    } pc_sel_e;

    typedef enum logic [1:0] {
        wb_none     = 2'd0,
        wb_pc_plus4 = 2'd1, // Link address
        wb_alu      = 2'd2,
        wb_mem      = 2'd3
    } wb_sel_e;

    // R-type field layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    // I-type field layout
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    // Same 32-bit word seen as R or I format
    typedef union packed {
        inst_r_t r_view;
        inst_i_t i_view;
    } inst_u;

    typedef struct packed {
        alu_op_e    alu_op;
        op1_sel_e   op1_sel;
        op2_sel_e   op2_sel;
        pc_sel_e    pc_sel;
        logic       rf_we;
        logic       mem_en;
        logic       mem_wen;
        wb_sel_e    wb_sel;
        logic [2:0] mem_access; // Size/sign code, funct3 of load or store
        logic       is_ebreak;
    } ctrl_word_t;

    // Token entering the pipe
    typedef struct packed {
        inst_u inst;
        logic  br_eq;  // rs1 == rs2
        logic  br_lt;  // rs1 < rs2 signed
        logic  br_ltu; // rs1 < rs2 unsigned
    } dec_req_t;

    // Token between decode and branch stage
    typedef struct packed {
        ctrl_word_t ctrl;
        logic       is_branch;
        logic [2:0] funct3;
        logic       br_eq;
        logic       br_lt;
        logic       br_ltu;
    } dec_mid_t;

endpackage

// ==== rv32_decode_stage.sv ====
// First pipe stage: looks up the RV32I control table and registers the token for branch resolve
`timescale 1ns/100ps

module rv32_decode_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv32_ctrl_pkg::dec_req_t req,
    input  logic                   req_valid,
    output logic                   req_ready,
    output rv32_ctrl_pkg::dec_mid_t mid,
    output logic                   mid_valid,
    input  logic                   mid_ready
);

    import rv32_ctrl_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_imm;      // OP-IMM rather than OP
    logic       f7_ok;       // funct7 legal for the non-shift ALU ops
    logic       alu_ok;      // funct3/funct7 pair is in the table
    alu_op_e    alu_sel;
    logic       ebreak_hit;
    ctrl_word_t word;
    logic       is_branch;
    dec_mid_t   mid_next;

    assign opcode = req.inst.r_view.opcode;
    assign funct3 = req.inst.r_view.funct3;
    assign funct7 = req.inst.r_view.funct7;
    assign is_imm = (opcode == opc_op_imm);
    assign f7_ok  = is_imm || (funct7 == f7_base); // Immediates ignore upper bits

    // Only the exact canonical encoding counts
    assign ebreak_hit = (req.inst.i_view.opcode == opc_system) &&
                        (req.inst.i_view.imm12 == 12'd1) &&
                        (req.inst.i_view.rs1 == 5'd0) &&
                        (req.inst.i_view.funct3 == 3'd0) &&
                        (req.inst.i_view.rd == 5'd0);

    // ALU op shared by OP and OP-IMM
    always_comb begin
        alu_ok  = f7_ok;
        alu_sel = alu_add;
        case (funct3)
            3'b000: begin
                if (is_imm || funct7 == f7_base) begin
                    alu_sel = alu_add;                 // ADD, ADDI
                end else if (funct7 == f7_alt) begin
                    alu_sel = alu_sub;                 // No SUBI exists
                    alu_ok  = 1'b1;
                end else begin
                    alu_ok  = 1'b0;
                end
            end
            3'b001: alu_sel = alu_sll;
            3'b010: alu_sel = alu_slt;
            3'b011: alu_sel = alu_sltu;
            3'b100: alu_sel = alu_xor;
            3'b101: begin
                if (funct7 == f7_base) begin
                    alu_sel = alu_srl;
                    alu_ok  = 1'b1;
                end else if (funct7 == f7_alt) begin
                    alu_sel = alu_sra;                 // SRA and SRAI alike
                    alu_ok  = 1'b1;
                end else begin
                    alu_ok  = 1'b0;                    // Checked even for SRLI/SRAI
                end
            end
            3'b110: alu_sel = alu_or;
            default: alu_sel = alu_and;
        endcase
    end

    // Control table, all-zero word on a miss
    always_comb begin
        word      = '0;
        is_branch = 1'b0;
        case (opcode)
            opc_op, opc_op_imm: begin
                if (alu_ok) begin
                    word.alu_op  = alu_sel;
                    word.op1_sel = op1_rs1;
                    word.op2_sel = is_imm ? op2_imm : op2_rs2;
                    word.rf_we   = 1'b1;
                    word.wb_sel  = wb_alu;
                end
            end
            opc_load: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                    word.op2_sel    = op2_imm;             // Base plus offset
                    word.rf_we      = 1'b1;
                    word.mem_en     = 1'b1;
                    word.wb_sel     = wb_mem;
                    word.mem_access = funct3;              // LB LH LW LBU LHU
                end
            end
            opc_store: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
                    word.op2_sel    = op2_simm;
                    word.mem_en     = 1'b1;
                    word.mem_wen    = 1'b1;
                    word.wb_sel     = wb_none;
                    word.mem_access = funct3;              // SB SH SW
                end
            end
            opc_branch: begin
                is_branch = 1'b1;                          // Resolved next stage
                if (funct3 inside {f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu}) begin
                    word.op2_sel = op2_none;
                    word.wb_sel  = wb_alu;
                end
            end
            opc_jal: begin
                word.pc_sel = pc_jal;
                word.rf_we  = 1'b1;
                word.wb_sel = wb_pc_plus4;                 // Link register
            end
            opc_jalr: begin
                if (funct3 == 3'b000) begin
                    word.op2_sel = op2_imm;
                    word.pc_sel  = pc_jalr;
                    word.rf_we   = 1'b1;
                    word.wb_sel  = wb_pc_plus4;
                end
            end
            opc_auipc: begin
                word.op1_sel = op1_pc;
                word.rf_we   = 1'b1;
                word.wb_sel  = wb_alu;
            end
            opc_lui: begin
                word.alu_op  = alu_lui;
                word.op1_sel = op1_pc;
                word.rf_we   = 1'b1;
                word.wb_sel  = wb_alu;
            end
            opc_system: word.is_ebreak = ebreak_hit;    // Nothing else decoded here
            default: word = '0;
        endcase
    end

    always_comb begin
        mid_next.ctrl      = word;
        mid_next.is_branch = is_branch;
        mid_next.funct3    = funct3;                   // Branch condition select
        mid_next.br_eq     = req.br_eq;
        mid_next.br_lt     = req.br_lt;
        mid_next.br_ltu    = req.br_ltu;
    end

    assign req_ready = !mid_valid || mid_ready;       // Empty or draining

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mid_valid <= 1'b0;
        end else if (req_ready) begin
            mid_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            mid <= mid_next;                            // Payload only on transfer
        end
    end

endmodule

// ==== verilog.f ====
rv32_ctrl_pkg.sv
rv32_decode_stage.sv
rv32_branch_stage.sv
rv32_ctrl_pipe.sv
rv32_ctrl_pipe_checker.sv
rv32_ctrl_pipe_tb.sv
